// File: vlog.f
+incdir+.
snd_isa_pkg.sv
snd_map_pkg.sv
snd_decode.sv
snd_seq.sv
snd_tone.sv
snd_top.sv
tb_clk.sv
tb_snd.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
verilator --binary --timing --assert -Wno-fatal --top-module tb_snd -f vlog.f \
    -o tb_snd_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_snd_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// File: tb_snd.sv
`timescale 1ns/1ns

`include "snd_config.svh"

/* sound board testbench whose ROM model answers with 0-3 wait cycles drawn from an LCG
   each table row runs one program from reset until its HALT byte is fetched */
module tb_snd;

    localparam int NROWS = 5;

    logic               clk;
    logic               rst;
    logic               reset_req;
    logic [15:0]        rom_addr;
    logic               rom_cs;
    logic               rom_ok;
    logic [7:0]         rom_data;
    logic [7:0]         snd_latch0;
    logic [7:0]         snd_latch1;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic               sample;

    logic [7:0]  rom_mem [0:65535];
    logic [31:0] lcg_state = 32'hf147_3ee4;
    int          rom_wait = -1;  // cycles left before rom_ok or -1 when idle
    int          row;
    bit          halted;         // HALT byte fetched
    bit          watch_seen;
    int          since_pulse;    // cycles since the last sample pulse or -1 before the first

    // stimulus and expected values with one entry per row
    logic [191:0] t_prog   [NROWS];  // program bytes with the first byte leftmost
    int           t_len    [NROWS];
    logic [7:0]   t_latch0 [NROWS];
    logic [7:0]   t_latch1 [NROWS];
    int           t_pulses [NROWS];
    int           t_left   [NROWS];  // amplitude on the toggle row
    int           t_right  [NROWS];
    bit           t_toggle [NROWS];
    logic [15:0]  t_watch  [NROWS];  // rom_addr that must appear with rom_cs
    logic [15:0]  t_halt   [NROWS];  // address of the HALT byte

    tb_clk i_clk (.reset_req(reset_req), .clk(clk), .rst(rst));

    snd_top i_snd_top (
        .clk        (clk),
        .rst        (rst),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .snd_latch0 (snd_latch0),
        .snd_latch1 (snd_latch1),
        .left       (left),
        .right      (right),
        .sample     (sample)
    );

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]);  // upper bits are less regular
    endfunction

    // ROM fill that depends on every address bit
    function automatic logic [7:0] rom_fill(input logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ 8'h3c;
    endfunction

    // square wave level of plus or minus vol * 128
    function automatic int level(input int vol, input bit phase);
        return phase ? vol * 128 : -(vol * 128);
    endfunction

    task automatic set_row(input int r, input logic [191:0] prog, input int len,
                           input logic [7:0] l0, input logic [7:0] l1, input int pulses,
                           input int exp_l, input int exp_r, input bit toggle,
                           input logic [15:0] watch, input logic [15:0] halt);
        t_prog[r]   = prog;
        t_len[r]    = len;
        t_latch0[r] = l0;
        t_latch1[r] = l1;
        t_pulses[r] = pulses;
        t_left[r]   = exp_l;
        t_right[r]  = exp_r;
        t_toggle[r] = toggle;
        t_watch[r]  = watch;
        t_halt[r]   = halt;
    endtask

    task automatic check_eq(input string name, input logic signed [31:0] got,
                            input logic signed [31:0] want);
        if (got !== want) begin
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // one cycle sampled at the falling edge with the bus monitors
    task automatic step();
        @(negedge clk);
        if (halted) begin
            check_eq("rom_cs after HALT", rom_cs, 0);
        end
        if (rom_cs && rom_addr == t_watch[row]) begin
            watch_seen = 1'b1;
        end
        if (rom_cs && rom_ok && rom_addr == t_halt[row]) begin
            halted = 1'b1;  // HALT opcode taken at the next edge
        end
        if (sample) begin
            if (since_pulse >= 0) begin
                check_eq("sample spacing", since_pulse, `SND_SAMPLE_DIV);
            end
            since_pulse = 0;
        end
        if (since_pulse >= 0) begin
            since_pulse++;
        end
    endtask

    task automatic wait_pulses(input int n);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n) begin
            if (guard == n * `SND_SAMPLE_DIV + 4) fail_timeout("sample pulse");
            step();
            guard++;
            if (sample) seen++;
        end
    endtask

    // period 2 flips the phase on every third pulse after the first flip
    task automatic check_toggle(input int r);
        logic signed [15:0] prev;
        bit                 ph0;
        int                 tries;
        int                 want;
        prev  = left;
        tries = 0;
        wait_pulses(1);
        step();  // levels move one cycle after the strobe
        while (!(prev != 0 && left == -prev)) begin
            if (tries == 8) fail_timeout("first phase flip");
            prev = left;
            wait_pulses(1);
            step();
            tries++;
        end
        ph0 = left > 0;
        check_eq("left at flip", left, ph0 ? t_left[r] : -t_left[r]);
        for (int k = 1; k <= t_pulses[r]; k++) begin
            wait_pulses(1);
            step();
            want = (ph0 ^ ((k / 3) % 2 == 1)) ? t_left[r] : -t_left[r];
            check_eq("left", left, want);
            check_eq("right", right, t_right[r]);
        end
    endtask

    task automatic run_row(input int r);
        int guard;
        row = r;
        @(posedge clk);
        #1;
        reset_req  = 1'b1;  // DUT is halted so ROM can change now
        snd_latch0 = t_latch0[r];
        snd_latch1 = t_latch1[r];
        for (int a = 0; a < 65536; a++) begin
            rom_mem[a] = rom_fill(16'(a));
        end
        for (int i = 0; i < t_len[r]; i++) begin
            rom_mem[i] = t_prog[r][(t_len[r] - 1 - i) * 8 +: 8];
        end
        @(posedge clk);
        #1;
        reset_req = 1'b0;
        guard = 0;
        do begin
            @(negedge clk);
            guard++;
            if (rst && guard > 20) fail_timeout("reset release");
        end while (rst);
        halted      = 1'b0;
        watch_seen  = 1'b0;
        since_pulse = -1;
        // reset state before the first fetch goes to 0000
        check_eq("left", left, 0);
        check_eq("right", right, 0);
        check_eq("rom_cs", rom_cs, 0);
        guard = 0;
        while (!rom_cs) begin
            if (guard == 10) fail_timeout("first ROM request");
            step();
            guard++;
        end
        check_eq("rom_addr", rom_addr, 0);
        guard = 0;
        while (!halted) begin
            if (guard == 2000) fail_timeout("HALT fetch");
            step();
            guard++;
        end
        check_eq("watched rom_addr seen", watch_seen, 1);
        if (t_toggle[r]) begin
            check_toggle(r);
        end else begin
            wait_pulses(t_pulses[r]);
            step();
            check_eq("left", left, t_left[r]);
            check_eq("right", right, t_right[r]);
        end
    endtask

    // ROM model draws one wait per access and shows the byte only with rom_ok
    always @(posedge clk) begin
        #1;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        if (!rom_cs) begin
            rom_wait = -1;
        end else begin
            if (rom_wait < 0) rom_wait = lcg_next() % 4;
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_mem[rom_addr];
                rom_wait = -1;
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    initial begin
        reset_req   = 1'b0;
        rom_ok      = 1'b0;
        rom_data    = 8'h00;
        snd_latch0  = 8'h00;
        snd_latch1  = 8'h00;
        row         = 0;
        halted      = 1'b0;
        watch_seen  = 1'b0;
        since_pulse = -1;
        // LD F00A, ST F002, HALT
        set_row(0, 192'h02_0a_f0_03_02_f0_05, 7, 8'h2d, 8'h00, 2,
                level(8'h2d, 1'b0), 0, 1'b0, 16'h0000, 16'h0006);
        // LDI 1, ST F008, LD 8005, ST F006, HALT
        set_row(1, 192'h01_01_03_08_f0_02_05_80_03_06_f0_05, 12, 8'h00, 8'h00, 2,
                0, level(rom_fill(16'hc005), 1'b0), 1'b0, 16'hc005, 16'h000b);
        // LD F00C, ST D123, LDI 0, LD D123, ST F002, LD E000, ST F006, HALT
        set_row(2, 192'h02_0c_f0_03_23_d1_01_00_02_23_d1_03_02_f0_02_00_e0_03_06_f0_05,
                21, 8'h00, 8'h93, 2, level(8'h93, 1'b0), level(255, 1'b0), 1'b0,
                16'h0000, 16'h0014);
        // LDI 10, ST F002, LDI 2, ST F000, HALT
        set_row(3, 192'h01_0a_03_02_f0_01_02_03_00_f0_05, 11, 8'h00, 8'h00, 12,
                level(10, 1'b1), 0, 1'b1, 16'h0000, 16'h000a);
        // LDI 33, ST F002, LDI 77, JP 000D, ST F002 skipped, HALT
        set_row(4, 192'h01_33_03_02_f0_01_77_04_0d_00_03_02_f0_05, 14, 8'h00, 8'h00, 6,
                level(8'h33, 1'b0), 0, 1'b0, 16'h0000, 16'h000d);
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb_clk.sv
`timescale 1ns/1ns

/* testbench clock and reset, 20 ns period, reset high over 4 rising edges
   at start and again after each one-cycle reset_req, changes 1 ns after an edge */
module tb_clk (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    int   hold;  // edges still to spend in reset
    logic req;   // request seen at the edge

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        hold = 4;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        req = reset_req;  // tb drives it away from the edge
        #1;
        if (req) begin
            hold = 4;
        end else if (hold != 0) begin
            hold = hold - 1;
        end
        rst = req || hold != 0;
    end

endmodule

// File: snd_top.sv
`timescale 1ns/1ns

/* sound board top, sequencer core plus decoder plus tone generator
   ROM lives outside and answers rom_cs with rom_ok */
module snd_top (
    input  logic               clk,
    input  logic               rst,
    output logic [15:0]        rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    input  logic [7:0]         snd_latch0,
    input  logic [7:0]         snd_latch1,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    logic [15:0] bus_addr;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_dout;
    logic [7:0]  bus_din;
    logic        bus_ok;
    logic        tone_we;
    logic [1:0]  tone_sel;
    logic [7:0]  tone_data;

    snd_seq i_seq (
        .clk      (clk),
        .rst      (rst),
        .bus_addr (bus_addr),
        .bus_rd   (bus_rd),
        .bus_wr   (bus_wr),
        .bus_dout (bus_dout),
        .bus_din  (bus_din),
        .bus_ok   (bus_ok)
    );

    snd_decode i_decode (
        .clk        (clk),
        .rst        (rst),
        .bus_addr   (bus_addr),
        .bus_rd     (bus_rd),
        .bus_wr     (bus_wr),
        .bus_dout   (bus_dout),
        .bus_din    (bus_din),
        .bus_ok     (bus_ok),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .snd_latch0 (snd_latch0),
        .snd_latch1 (snd_latch1),
        .tone_we    (tone_we),
        .tone_sel   (tone_sel),
        .tone_data  (tone_data)
    );

    snd_tone i_tone (
        .clk       (clk),
        .rst       (rst),
        .tone_we   (tone_we),
        .tone_sel  (tone_sel),
        .tone_data (tone_data),
        .left      (left),
        .right     (right),
        .sample    (sample)
    );

endmodule

// File: snd_tone.sv
`timescale 1ns/1ns

`include "snd_config.svh"

/* two square wave channels whose counters advance once per sample strobe
   period 0 holds the phase, so the output sits at minus volume times 128 */
module snd_tone (
    input  logic               clk,
    input  logic               rst,
    input  logic               tone_we,
    input  logic [1:0]         tone_sel,
    input  logic [7:0]         tone_data,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    localparam int DW = $clog2(`SND_SAMPLE_DIV);

    logic [DW-1:0]      div;
    logic [7:0]         period  [2];
    logic [7:0]         vol     [2];
    logic [7:0]         cnt     [2];
    logic [7:0]         cnt_nxt [2];
    logic [1:0]         phase;
    logic [1:0]         ph_nxt;
    logic [15:0]        amp     [2];
    logic signed [15:0] lvl     [2];

    // next counter and phase per channel for the sample strobe
    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            cnt_nxt[ch] = cnt[ch] + 8'd1;
            ph_nxt[ch]  = phase[ch];
            if (period[ch] == 8'd0) begin
                cnt_nxt[ch] = 8'd0;          // stopped channel
            end else if (cnt[ch] == period[ch]) begin
                cnt_nxt[ch] = 8'd0;
                ph_nxt[ch]  = ~phase[ch];
            end
            amp[ch] = {1'b0, vol[ch], 7'd0}; // volume times 128
            lvl[ch] = ph_nxt[ch] ? signed'(amp[ch]) : -signed'(amp[ch]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div    <= '0;
            sample <= 1'b0;
            phase  <= 2'b00;
            left   <= 16'sd0;
            right  <= 16'sd0;
            for (int ch = 0; ch < 2; ch++) begin
                period[ch] <= 8'd0;
                vol[ch]    <= 8'd0;
                cnt[ch]    <= 8'd0;
            end
        end else begin
            div    <= div + 1'b1;  // wraps at the sample rate
            sample <= (div == DW'(`SND_SAMPLE_DIV - 1));
            if (tone_we) begin
                case (tone_sel)
                    snd_map_pkg::TONE0_PERIOD: period[0] <= tone_data;
                    snd_map_pkg::TONE0_VOL:    vol[0]    <= tone_data;
                    snd_map_pkg::TONE1_PERIOD: period[1] <= tone_data;
                    snd_map_pkg::TONE1_VOL:    vol[1]    <= tone_data;
                endcase
            end
            if (sample) begin
                // outputs move only right after the strobe
                for (int ch = 0; ch < 2; ch++) begin
                    cnt[ch] <= cnt_nxt[ch];
                end
                phase <= ph_nxt;
                left  <= lvl[0];
                right <= lvl[1];
            end
        end
    end

    // strobe is a single clock wide
    a_sample_pulse: assert property (@(posedge clk) disable iff (rst)
        sample |=> !sample);

endmodule

// File: snd_seq.sv
`timescale 1ns/1ns

/* sound sequencer core with a registered bus, first fetch starts one cycle after reset
   reads hold bus_rd until bus_ok, writes are a single bus_wr cycle
   HALT drops all bus traffic until the next reset */
module snd_seq (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] bus_addr,
    output logic        bus_rd,
    output logic        bus_wr,
    output logic [7:0]  bus_dout,
    input  logic [7:0]  bus_din,
    input  logic        bus_ok
);

    snd_isa_pkg::seq_state_e state;
    snd_isa_pkg::opcode_e    op;      // opcode under execution
    logic [15:0]             pc;      // next ROM byte to fetch
    logic [15:0]             pc_inc;
    logic [15:0]             target;  // 16-bit operand once the high byte arrives
    logic [7:0]              acc;
    logic [7:0]              lo;      // operand low byte

    assign pc_inc = pc + 16'd1;
    assign target = {bus_din, lo};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= snd_isa_pkg::FETCH_OP;
            pc       <= 16'd0;
            bus_addr <= 16'd0;
            bus_rd   <= 1'b0;
            bus_wr   <= 1'b0;
        end else begin
            bus_wr <= 1'b0;  // one cycle strobe
            case (state)
                snd_isa_pkg::FETCH_OP: begin
                    if (!bus_rd) begin
                        bus_rd   <= 1'b1;  // start of the first fetch
                        bus_addr <= pc;
                    end else if (bus_ok) begin
                        op       <= snd_isa_pkg::opcode_e'(bus_din);
                        pc       <= pc_inc;
                        bus_addr <= pc_inc;  // keep streaming ROM bytes
                        case (bus_din)
                            snd_isa_pkg::OP_LDI,
                            snd_isa_pkg::OP_LD,
                            snd_isa_pkg::OP_ST,
                            snd_isa_pkg::OP_JP: begin
                                state <= snd_isa_pkg::FETCH_LO;
                            end
                            snd_isa_pkg::OP_HALT: begin
                                state  <= snd_isa_pkg::HALTED;
                                bus_rd <= 1'b0;
                            end
                            default: begin
                                state <= snd_isa_pkg::FETCH_OP;  // NOP and unknown codes
                            end
                        endcase
                    end
                end
                snd_isa_pkg::FETCH_LO: begin
                    if (bus_ok) begin
                        lo       <= bus_din;
                        pc       <= pc_inc;
                        bus_addr <= pc_inc;
                        if (op == snd_isa_pkg::OP_LDI) begin
                            acc   <= bus_din;  // immediate, done
                            state <= snd_isa_pkg::FETCH_OP;
                        end else begin
                            state <= snd_isa_pkg::FETCH_HI;
                        end
                    end
                end
                snd_isa_pkg::FETCH_HI: begin
                    if (bus_ok) begin
                        pc <= pc_inc;  // points at the next opcode
                        case (op)
                            snd_isa_pkg::OP_LD: begin
                                state    <= snd_isa_pkg::MEM_RD;
                                bus_addr <= target;
                            end
                            snd_isa_pkg::OP_ST: begin
                                state    <= snd_isa_pkg::MEM_WR;
                                bus_rd   <= 1'b0;
                                bus_wr   <= 1'b1;
                                bus_addr <= target;
                                bus_dout <= acc;
                            end
                            default: begin
                                // OP_JP
                                state    <= snd_isa_pkg::FETCH_OP;
                                pc       <= target;
                                bus_addr <= target;
                            end
                        endcase
                    end
                end
                snd_isa_pkg::MEM_RD: begin
                    if (bus_ok) begin
                        acc      <= bus_din;
                        state    <= snd_isa_pkg::FETCH_OP;
                        bus_addr <= pc;
                    end
                end
                snd_isa_pkg::MEM_WR: begin
                    // write lands at this edge, resume fetching
                    state    <= snd_isa_pkg::FETCH_OP;
                    bus_rd   <= 1'b1;
                    bus_addr <= pc;
                end
                default: begin
                    state  <= snd_isa_pkg::HALTED;  // stays here
                    bus_rd <= 1'b0;
                end
            endcase
        end
    end

    // read and write strobes never overlap
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(bus_rd && bus_wr));

    // a stalled read keeps its address until the target answers
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        bus_rd && !bus_ok |=> bus_rd && $stable(bus_addr));

endmodule

// File: snd_decode.sv
`timescale 1ns/1ns

`include "snd_config.svh"

/* bus decoder for the sound CPU. RAM has a combinational read port
   ROM reads stall on rom_ok, all other reads and writes finish in one cycle */
module snd_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] bus_addr,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  logic [7:0]  bus_dout,
    output logic [7:0]  bus_din,
    output logic        bus_ok,
    output logic [15:0] rom_addr,
    output logic        rom_cs,
    input  logic [7:0]  rom_data,
    input  logic        rom_ok,
    input  logic [7:0]  snd_latch0,
    input  logic [7:0]  snd_latch1,
    output logic        tone_we,
    output logic [1:0]  tone_sel,
    output logic [7:0]  tone_data
);

    snd_map_pkg::target_e tgt;
    logic                 bank;
    logic [7:0]           ram [0:(1 << `SND_RAM_AW) - 1];
    logic [7:0]           ram_q;

    // region decode
    always_comb begin
        tgt = snd_map_pkg::T_NONE;
        if (!bus_addr[15] || bus_addr[15:14] == 2'b10) begin
            tgt = snd_map_pkg::T_ROM;                       // fixed and banked windows
        end else if (bus_addr[15:12] == snd_map_pkg::RAM_PAGE) begin
            tgt = snd_map_pkg::T_RAM;
        end else if (bus_addr[15:4] == snd_map_pkg::IO_PAGE && !bus_addr[0]) begin
            case (bus_addr[3:1])
                snd_map_pkg::IO_BANK:   tgt = snd_map_pkg::T_BANK;
                snd_map_pkg::IO_LATCH0: tgt = snd_map_pkg::T_LATCH0;
                snd_map_pkg::IO_LATCH1: tgt = snd_map_pkg::T_LATCH1;
                default: begin
                    if (!bus_addr[3]) begin
                        tgt = snd_map_pkg::T_TONE;          // F000-F006
                    end
                end
            endcase
        end
    end

    // bit 15 picks the window, banked reads put the bank bit on 14
    assign rom_addr = bus_addr[15] ? {1'b1, bank, bus_addr[13:0]}
                                   : {1'b0, bus_addr[14:0]};
    assign rom_cs   = bus_rd && tgt == snd_map_pkg::T_ROM;
    assign bus_ok   = (tgt == snd_map_pkg::T_ROM) ? rom_ok : 1'b1;

    // tone block sees a plain register write
    assign tone_we   = bus_wr && tgt == snd_map_pkg::T_TONE;
    assign tone_sel  = bus_addr[2:1];
    assign tone_data = bus_dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (bus_wr && tgt == snd_map_pkg::T_BANK) begin
            bank <= bus_dout[0];
        end
    end

    // work RAM, aliased across the page
    always_ff @(posedge clk) begin
        if (bus_wr && tgt == snd_map_pkg::T_RAM) begin
            ram[bus_addr[`SND_RAM_AW-1:0]] <= bus_dout;
        end
    end

    assign ram_q = ram[bus_addr[`SND_RAM_AW-1:0]];

    always_comb begin
        case (tgt)
            snd_map_pkg::T_ROM:    bus_din = rom_data;
            snd_map_pkg::T_RAM:    bus_din = ram_q;
            snd_map_pkg::T_LATCH0: bus_din = snd_latch0;
            snd_map_pkg::T_LATCH1: bus_din = snd_latch1;
            default:               bus_din = 8'hff;  // bank and tone are write only
        endcase
    end

    // the core never writes while a ROM read is pending
    a_no_wr_in_rom: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> !bus_wr);

endmodule

// File: snd_map_pkg.sv
/* sound CPU memory map. ROM below 8000, banked ROM 8000-BFFF, RAM at Dxxx,
   I/O page at F000-F00C on even addresses only. Anything else is unmapped */
package snd_map_pkg;

    // what a bus address selects
    typedef enum logic [2:0] {
        T_NONE,   // unmapped, reads 8'hff
        T_ROM,    // fixed or banked window
        T_RAM,    // work RAM, aliased over the page
        T_BANK,   // bank select, bit 0
        T_LATCH0, // main CPU latch 0
        T_LATCH1, // main CPU latch 1
        T_TONE    // tone registers, write only
    } target_e;

    localparam logic [3:0]  RAM_PAGE = 4'hD;     // bits 15:12
    localparam logic [11:0] IO_PAGE  = 12'hF00;  // bits 15:4

    // I/O index, address bits 3:1, 0-3 are the tone registers
    localparam logic [2:0] IO_BANK   = 3'd4; // F008
    localparam logic [2:0] IO_LATCH0 = 3'd5; // F00A
    localparam logic [2:0] IO_LATCH1 = 3'd6; // F00C

    // tone register index, address bits 2:1
    localparam logic [1:0] TONE0_PERIOD = 2'd0;
    localparam logic [1:0] TONE0_VOL    = 2'd1;
    localparam logic [1:0] TONE1_PERIOD = 2'd2;
    localparam logic [1:0] TONE1_VOL    = 2'd3;

endpackage

// File: snd_isa_pkg.sv
/* sequencer instruction set, one opcode byte followed by 0, 1 or 2 operand bytes
   operands are little endian, low byte first. Unknown opcodes behave as NOP */
package snd_isa_pkg;

    // opcode byte values as stored in the sound ROM
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00, // no operand
        OP_LDI  = 8'h01, // acc <= imm8
        OP_LD   = 8'h02, // acc <= mem[addr16]
        OP_ST   = 8'h03, // mem[addr16] <= acc
        OP_JP   = 8'h04, // pc <= addr16
        OP_HALT = 8'h05  // stop until reset
    } opcode_e;

    // fetch / execute steps of the core
    typedef enum logic [2:0] {
        FETCH_OP, // opcode byte on the bus
        FETCH_LO, // immediate or address low byte
        FETCH_HI, // address high byte
        MEM_RD,   // data read for LD
        MEM_WR,   // write strobe for ST
        HALTED    // bus idle for good
    } seq_state_e;

endpackage

// File: snd_config.svh
/* build constants for the sound board
   RAM width sets the aliasing of the Dxxx page */
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// work RAM address bits, 2 KB
`define SND_RAM_AW 11

// clocks between two sample strobes, a power of two keeps the divider simple
`define SND_SAMPLE_DIV 16

`endif
